/* tb.f */
+incdir+verilog
verilog/obj_pkg.sv
verilog/obj_table_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_top.sv
verification/obj_rom_model.sv
verification/tb_obj.sv

/* Makefile */
# Verilator build and run for the object subsystem testbench

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_obj -Mdir obj_dir -o tb_obj

run: compile
	./obj_dir/tb_obj | tee sim.log
	grep -q "^STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* verification/tb_obj.sv */
// Object subsystem testbench
// Loads a small object table, runs a series of scan lines and checks
// line buffer output, ROM fetches and running offsets against a reference model

`timescale 1ns/1ps
`include "obj_config.svh"

module tb_obj;
    import obj_pkg::*;

    localparam int LINE_CYC = 2048;    // Clocks between hstart pulses
    localparam int N_LINES  = 10;
    localparam int WATCH_NS = N_LINES * LINE_CYC * 4 + 4000;

    logic        clk = 1'b0;
    logic        rst;
    tbl_addr_t   cpu_addr;
    logic [15:0] cpu_din;
    logic        cpu_we;
    logic [15:0] cpu_dout;
    logic        flip;
    logic        hstart;
    logic [8:0]  vrender;
    xpos_t       hdump;
    obj_pxl_t    pix;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    logic        rom_ok;
    logic [15:0] rom_data;

    logic [15:0] tbl [0:`OBJ_CNT-1][0:`OBJ_WORDS-1];  // Reference table copy
    obj_pxl_t    exp_line [0:`OBJ_LINE_W-1];         // Line being drawn
    obj_pxl_t    shown [0:`OBJ_LINE_W-1];            // Line on the video side
    logic        quiet;                              // Out of reset, no line yet
    logic        chk_en;
    xpos_t       chk_x;
    obj_pxl_t    chk_pix;
    logic        ofs_en;
    int          ofs_obj;
    logic [15:0] ofs_exp;
    int          err_pix;
    int          err_ofs;
    int          err_idle;
    int          err_rom;
    rom_addr_t   rom_exp [0:1023];                   // Predicted fetch addresses in order
    int          rom_cnt;                            // Fetches predicted so far
    int          rom_rd;                             // Fetches seen so far
    logic        rom_cs_q;
    rom_addr_t   rom_next;
    int          i;

    obj_top u_dut (
        .rst      (rst),
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender),
        .hdump    (hdump),
        .pix      (pix),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    obj_rom_model u_rom (
        .rst      (rst),
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    always #2 clk = ~clk;

    // Nothing moves before the first line
    a_idle: assert property (@(posedge clk) disable iff (rst)
        quiet |-> !u_dut.dr_start && !rom_cs && !u_dut.tbl_we && pix == '0)
        else begin
            err_idle++;
            $display("FAIL %0t: activity before the first line", $time);
        end

    a_pix: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pix == chk_pix)
        else begin
            err_pix++;
            $display("FAIL %0t: pix at x %0d is %h, expected %h", $time,
                $sampled(chk_x), $sampled(pix), $sampled(chk_pix));
        end

    a_ofs: assert property (@(posedge clk) disable iff (rst)
        ofs_en |-> cpu_dout == ofs_exp)
        else begin
            err_ofs++;
            $display("FAIL %0t: scratch of object %0d is %h, expected %h", $time,
                $sampled(ofs_obj), $sampled(cpu_dout), $sampled(ofs_exp));
        end

    assign rom_next = rom_exp[rom_rd[9:0]];

    // A new fetch starts where rom_cs rises
    always @(posedge clk) begin
        if (rst) begin
            rom_cs_q <= 1'b0;
            rom_rd   <= 0;
        end else begin
            rom_cs_q <= rom_cs;
            if (rom_cs && !rom_cs_q) begin
                rom_rd <= rom_rd + 1;
            end
        end
    end

    a_rom: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_cs_q |-> rom_rd < rom_cnt && rom_addr == rom_next)
        else begin
            err_rom++;
            $display("FAIL %0t: sprite ROM fetch %0d at %h, expected %h", $time,
                $sampled(rom_rd), $sampled(rom_addr), $sampled(rom_next));
        end

    // Same address formula as the ROM model
    function automatic logic [15:0] sprite_word(input logic [17:0] a);
        logic [31:0] m;
        m = 32'(a) * 32'h0001_9E37 + 32'h3C6E_F35F;
        return m[31:16] ^ m[15:0];
    endfunction

    // Host write, entered and left 1 ns after an edge
    task automatic cpu_write(input tbl_addr_t a, input logic [15:0] d);
        cpu_addr = a;
        cpu_din  = d;
        cpu_we   = 1'b1;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    task automatic put_word(input int obj, input int w, input logic [15:0] d);
        tbl[obj][w] = d;
        cpu_write(tbl_addr_t'(obj * `OBJ_WORDS + w), d);
    endtask

    // Bounds, xpos, pitch, offset, attr; scratch starts at the offset
    task automatic put_obj(input int obj, input logic [15:0] w0, input logic [15:0] w1,
                           input logic [15:0] w2, input logic [15:0] w3,
                           input logic [15:0] w4);
        put_word(obj, 0, w0);
        put_word(obj, 1, w1);
        put_word(obj, 2, w2);
        put_word(obj, 3, w3);
        put_word(obj, 4, w4);
        put_word(obj, 5, 16'h0);
        put_word(obj, 6, 16'h0);
        put_word(obj, 7, w3);
    endtask

    // One object row into exp_line, first color at a pixel wins
    task automatic draw_row(input xpos_t xs, input logic [15:0] ofs, input logic [15:0] attr);
        xpos_t       x;
        logic [17:0] a;
        logic [15:0] d;
        logic [3:0]  nib;
        logic        stop;
        int          w;
        int          n;
        x    = xs;
        a    = {attr[6:4], ofs[14:0]};
        stop = 1'b0;
        for (w = 0; w < `OBJ_MAX_WORDS && !stop; w++) begin
            rom_exp[rom_cnt[9:0]] = a;      // Fetch order seen on the ROM bus
            rom_cnt++;
            d = sprite_word(a);
            for (n = 0; n < 4 && !stop; n++) begin
                nib = ofs[15] ? d[4*n +: 4] : d[12-4*n +: 4];  // Mirrored takes LSB first
                if (nib == 4'hF) begin
                    stop = 1'b1;
                end else begin
                    if (nib != 4'h0 && exp_line[x].color == 4'h0) begin
                        exp_line[x] = '{prio: attr[1:0], pal: attr[13:8], color: nib};
                    end
                    x = x + 1'b1;
                end
            end
            a[14:0] = ofs[15] ? a[14:0] - 1'b1 : a[14:0] + 1'b1;
        end
    endtask

    // Reference scan of line v, also advances scratch offsets
    task automatic predict_line(input logic [8:0] v);
        logic [7:0]  top;
        logic [7:0]  bottom;
        logic [15:0] base;
        logic        stop;
        int          k;
        for (k = 0; k < `OBJ_LINE_W; k++) begin
            exp_line[k] = '0;
        end
        stop = v > 9'(`OBJ_VISIBLE);  // Line skipped
        for (k = 0; k < `OBJ_CNT && !stop; k++) begin
            bottom = tbl[k][0][15:8];
            top    = tbl[k][0][7:0];
            if (bottom >= `OBJ_END_MARK) begin
                stop = 1'b1;
            end else if (top <= v[7:0] && v[7:0] < bottom && top < bottom) begin
                base        = (top == v[7:0]) ? tbl[k][3] : tbl[k][7];
                tbl[k][7]   = base + tbl[k][2];
                draw_row(tbl[k][1][8:0], base, tbl[k][4]);
            end
        end
    endtask

    task automatic check_scratch(input int obj);
        cpu_addr = tbl_addr_t'(obj * `OBJ_WORDS + 7);
        @(posedge clk);
        #1;
        ofs_obj = obj;
        ofs_exp = tbl[obj][7];
        ofs_en  = 1'b1;
        @(posedge clk);
        #1;
        ofs_en = 1'b0;
    endtask

    // Start a line, sweep out the previous one, then read back offsets
    task automatic run_line(input logic f, input logic [8:0] vr);
        logic [8:0] v;
        int         k;
        v     = f ? 9'(`OBJ_VISIBLE) - vr : vr;
        shown = exp_line;
        predict_line(v);
        flip    = f;
        vrender = vr;
        hstart  = 1'b1;
        @(posedge clk);
        #1;
        hstart = 1'b0;
        quiet  = 1'b0;
        for (k = 0; k <= `OBJ_LINE_W; k++) begin
            hdump  = xpos_t'(k);
            chk_en = k > 0;                 // pix trails hdump by one clock
            chk_x  = xpos_t'(k - 1);
            if (k > 0) begin
                chk_pix = shown[k-1];
            end
            @(posedge clk);
            #1;
        end
        chk_en = 1'b0;
        repeat (LINE_CYC - 560) @(posedge clk);
        #1;
        for (k = 0; k < 7; k++) begin
            check_scratch(k);
        end
    endtask

    initial begin
        #(WATCH_NS);
        $display("Watchdog expired before the line sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        flip     = 1'b0;
        hstart   = 1'b0;
        vrender  = '0;
        hdump    = '0;
        quiet    = 1'b0;
        chk_en   = 1'b0;
        chk_x    = '0;
        chk_pix  = '0;
        ofs_en   = 1'b0;
        ofs_obj  = 0;
        ofs_exp  = '0;
        err_pix  = 0;
        err_ofs  = 0;
        err_idle = 0;
        err_rom  = 0;
        rom_cnt  = 0;
        for (i = 0; i < `OBJ_LINE_W; i++) begin
            exp_line[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst   = 1'b0;
        quiet = 1'b1;

        put_obj(0, 16'h2C28, 16'h0014, 16'h0003, 16'h0010, 16'h0512); // Lines 40..43
        put_obj(1, 16'h3226, 16'h0018, 16'h0005, 16'h8100, 16'h0921); // Mirrored overlap
        put_obj(2, 16'h6E64, 16'h003C, 16'h0001, 16'h0300, 16'h0330); // Out of zone
        put_obj(3, 16'h2A2A, 16'h0050, 16'h0001, 16'h0380, 16'h0440); // Bad bounds
        put_obj(4, 16'h302D, 16'h012C, 16'h0002, 16'h0200, 16'h3F03); // Lines 45..47
        put_obj(5, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000); // End marker
        put_obj(6, 16'h3C28, 16'h0064, 16'h0004, 16'h0400, 16'h0713); // Hidden by marker

        for (i = 0; i < 6; i++) begin
            run_line(1'b0, 9'(40 + i));
        end
        run_line(1'b0, 9'd240);     // Below the visible area
        run_line(1'b1, 9'd177);     // Flipped, line 46
        run_line(1'b1, 9'd176);     // Flipped, line 47
        run_line(1'b0, 9'd300);     // Shows line 47

        $display("Errors: pixel %0d, offset %0d, rom %0d, idle %0d",
            err_pix, err_ofs, err_rom, err_idle);
        if (err_pix + err_ofs + err_rom + err_idle == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verification/obj_rom_model.sv */
// Sprite ROM model
// Word data follows a fixed formula in the address, reply latency
// of 1 to 4 clocks comes from an LCG

`timescale 1ns/1ps

module obj_rom_model #(
    parameter logic [31:0] SEED = 32'h111c_ccd9
) (
    input  logic               rst,
    input  logic               clk,
    input  obj_pkg::rom_addr_t rom_addr,
    input  logic               rom_cs,
    output logic               rom_ok,
    output logic [15:0]        rom_data
);

    logic [31:0] lcg_state;
    logic [1:0]  wait_cnt;     // Extra clocks before the reply
    logic        pend;         // Request taken, reply owed

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mixes the whole address, gives zero, F and color nibbles
    function automatic logic [15:0] rom_word(input logic [17:0] a);
        logic [31:0] m;
        m = 32'(a) * 32'h0001_9E37 + 32'h3C6E_F35F;
        return m[31:16] ^ m[15:0];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lcg_state <= SEED;
            wait_cnt  <= '0;
            pend      <= 1'b0;
            rom_ok    <= 1'b0;
            rom_data  <= '0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !pend && !rom_ok) begin
                pend      <= 1'b1;
                lcg_state <= lcg_next(lcg_state);
                wait_cnt  <= lcg_state[17:16];  // Upper bits, low ones repeat fast
            end else if (pend) begin
                if (wait_cnt == 2'd0) begin
                    pend     <= 1'b0;
                    rom_ok   <= 1'b1;            // One clock pulse
                    rom_data <= rom_word(rom_addr);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/obj_top.sv */
// Object subsystem top
// Table RAM, line scanner, draw engine and line buffer

`timescale 1ns/1ps

module obj_top (
    input  logic               rst,
    input  logic               clk,

    // Host access to the object table
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  logic [15:0]        cpu_din,
    input  logic               cpu_we,
    output logic [15:0]        cpu_dout,

    // Video timing
    input  logic               flip,
    input  logic               hstart,
    input  logic [8:0]         vrender,
    input  obj_pkg::xpos_t     hdump,
    output obj_pkg::obj_pxl_t  pix,

    // Sprite ROM
    output obj_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  logic               rom_ok,
    input  logic [15:0]        rom_data
);
    import obj_pkg::*;

    tbl_addr_t   tbl_addr;
    logic [15:0] tbl_din;
    logic        tbl_we;
    logic [15:0] tbl_dout;

    logic        dr_start;
    obj_cmd_t    dr_cmd;
    logic        dr_busy;

    logic        wr_en;
    xpos_t       wr_x;
    obj_pxl_t    wr_pxl;

    obj_table_ram u_table (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .rst      (rst),
        .clk      (clk),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .tbl_dout (tbl_dout),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy)
    );

    obj_draw u_draw (
        .rst      (rst),
        .clk      (clk),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pxl   (wr_pxl)
    );

    obj_line_buf u_line_buf (
        .rst      (rst),
        .clk      (clk),
        .hstart   (hstart),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_pxl   (wr_pxl),
        .hdump    (hdump),
        .pix      (pix)
    );

endmodule

/* verilog/obj_line_buf.sv */
// Object line buffer
// Two banks swapped by hstart, one drawn while the other is shown
// First non-transparent write to a pixel wins, reads clear behind them

`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_buf (
    input  logic              rst,
    input  logic              clk,
    input  logic              hstart,

    // Draw side
    input  logic              wr_en,
    input  obj_pkg::xpos_t    wr_x,
    input  obj_pkg::obj_pxl_t wr_pxl,

    // Video side
    input  obj_pkg::xpos_t    hdump,
    output obj_pkg::obj_pxl_t pix
);
    import obj_pkg::*;

    localparam int DEPTH = 2 * `OBJ_LINE_W;
    localparam int AW    = $clog2(DEPTH);

    obj_pxl_t         mem [0:DEPTH-1];
    logic [DEPTH-1:0] filled;   // Pixel holds a drawn color
    logic             wbank;    // Bank being drawn
    logic [AW-1:0]    wa;
    logic [AW-1:0]    ra;
    logic             wr_land;

    assign wa      = {wbank, wr_x};
    assign ra      = {~wbank, hdump};   // Other bank goes to video
    assign wr_land = wr_en && wr_pxl.color != 4'd0 && !filled[wa];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbank  <= 1'b0;
            filled <= '0;
            pix    <= '0;
        end else begin
            if (hstart) begin
                wbank <= ~wbank;
            end
            pix        <= filled[ra] ? mem[ra] : '0;
            filled[ra] <= 1'b0;         // Ready for the next draw pass
            if (wr_land) begin
                filled[wa] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_land) begin
            mem[wa] <= wr_pxl;
        end
    end

endmodule

/* verilog/obj_draw.sv */
// Object draw engine
// Fetches sprite ROM words for one object row and writes
// its non-transparent pixels into the line buffer

`timescale 1ns/1ps
`include "obj_config.svh"

module obj_draw (
    input  logic               rst,
    input  logic               clk,

    // Command from scanner
    input  logic               dr_start,
    input  obj_pkg::obj_cmd_t  dr_cmd,
    output logic               dr_busy,

    // Sprite ROM
    output obj_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  logic               rom_ok,
    input  logic [15:0]        rom_data,

    // Line buffer
    output logic               wr_en,
    output obj_pkg::xpos_t     wr_x,
    output obj_pkg::obj_pxl_t  wr_pxl
);
    import obj_pkg::*;

    localparam int WCW = $clog2(`OBJ_MAX_WORDS);
    localparam logic [WCW-1:0] WORD_LAST = WCW'(`OBJ_MAX_WORDS - 1);

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_FETCH,
        DR_PIXEL
    } draw_state_t;

    draw_state_t    st;
    logic [1:0]     nib_cnt;
    logic [WCW-1:0] word_cnt;   // Words fetched for this row
    logic [15:0]    pxl_data;   // Shifts one nibble per pixel
    logic [3:0]     nib;
    logic           hflip;
    xpos_t          x;
    logic [5:0]     pal;
    logic [1:0]     prio;

    assign nib = hflip ? pxl_data[3:0] : pxl_data[15:12];   // LSB first when mirrored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= DR_IDLE;
            dr_busy  <= 1'b0;
            rom_cs   <= 1'b0;
            wr_en    <= 1'b0;
            nib_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            wr_en <= 1'b0;
            case (st)
                DR_IDLE: begin
                    if (dr_start) begin
                        dr_busy  <= 1'b1;
                        rom_cs   <= 1'b1;
                        word_cnt <= '0;
                        st       <= DR_FETCH;
                    end
                end
                DR_FETCH: begin
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        nib_cnt <= '0;
                        st      <= DR_PIXEL;
                    end
                end
                DR_PIXEL: begin
                    nib_cnt <= nib_cnt + 1'b1;
                    if (nib == 4'hF) begin
                        dr_busy <= 1'b0;    // Row terminator
                        st      <= DR_IDLE;
                    end else begin
                        wr_en <= nib != 4'd0;
                        if (nib_cnt == 2'd3) begin
                            if (word_cnt == WORD_LAST) begin
                                dr_busy <= 1'b0;
                                st      <= DR_IDLE;
                            end else begin
                                word_cnt <= word_cnt + 1'b1;
                                rom_cs   <= 1'b1;
                                st       <= DR_FETCH;
                            end
                        end
                    end
                end
                default: st <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == DR_IDLE && dr_start) begin
            hflip    <= dr_cmd.offset[15];
            pal      <= dr_cmd.pal;
            prio     <= dr_cmd.prio;
            x        <= dr_cmd.xpos;
            rom_addr <= {dr_cmd.bank, dr_cmd.offset[14:0]};
        end
        if (st == DR_FETCH && rom_ok) begin
            pxl_data <= rom_data;
        end
        if (st == DR_PIXEL) begin
            pxl_data <= hflip ? pxl_data >> 4 : pxl_data << 4;
            x        <= x + 1'b1;   // Gaps still advance x
            wr_x     <= x;
            wr_pxl   <= '{prio: prio, pal: pal, color: nib};
            if (nib_cnt == 2'd3) begin
                // Offset walks inside the bank
                rom_addr[14:0] <= hflip ? rom_addr[14:0] - 1'b1 : rom_addr[14:0] + 1'b1;
            end
        end
    end

    // ROM request held steady until acknowledged
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom_addr changed before rom_ok");

endmodule

/* verilog/obj_scan.sv */
// Object table scanner
// Walks the table once per line, picks objects crossing the line,
// advances their running ROM offset and issues draw commands

`timescale 1ns/1ps
`include "obj_config.svh"

module obj_scan (
    input  logic               rst,
    input  logic               clk,
    input  logic               flip,
    input  logic               hstart,
    input  logic [8:0]         vrender,

    // Object table
    output obj_pkg::tbl_addr_t tbl_addr,
    output logic [15:0]        tbl_din,
    output logic               tbl_we,
    input  logic [15:0]        tbl_dout,

    // Draw engine
    output logic               dr_start,
    output obj_pkg::obj_cmd_t  dr_cmd,
    input  logic               dr_busy
);
    import obj_pkg::*;

    scan_state_t st;
    obj_idx_t    cur_obj;
    logic [2:0]  idx;        // Word within entry
    logic        skip;       // Bubble while word 0 of next entry is read
    logic        restart;    // Line start carried over from an abort
    xpos_t       vline;      // Line being scanned
    xpos_t       vrf;

    // Fields gathered along the read sequence
    logic        first;      // Object starts on this line
    logic        last;       // Entry just updated was the final one
    xpos_t       xpos;
    logic [15:0] pitch;
    logic [15:0] start_off;
    logic [15:0] run_off;    // Offset sent with the command
    logic [2:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;

    logic [7:0]  top;
    logic [7:0]  bottom;
    logic        inzone;
    logic        badobj;
    logic [15:0] run_base;

    // Flipped screen scans from the bottom
    assign vrf = flip ? 9'(`OBJ_VISIBLE) - vrender : vrender;

    assign top    = tbl_dout[7:0];
    assign bottom = tbl_dout[15:8];
    assign inzone = vline[7:0] >= top && bottom > vline[7:0];
    assign badobj = top >= bottom;

    // Word 3 on the first line, scratch word afterwards
    assign run_base = first ? start_off : tbl_dout;

    assign tbl_addr = (st == IDLE) ? '0 : {cur_obj, idx}; // Word 0 of entry 0 primed
    assign tbl_din  = run_base + pitch;                   // Wraps like the hardware
    assign tbl_we   = st == UPDATE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= IDLE;
            cur_obj  <= '0;
            idx      <= '0;
            skip     <= 1'b0;
            restart  <= 1'b0;
            vline    <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                IDLE: begin
                    cur_obj <= '0;
                    idx     <= '0;
                    skip    <= 1'b0;
                    restart <= 1'b0;
                    if (hstart) begin
                        vline <= vrf;
                        if (vrf <= 9'(`OBJ_VISIBLE)) begin
                            st  <= BOUNDS;
                            idx <= 3'd1;
                        end
                    end else if (restart && vline <= 9'(`OBJ_VISIBLE)) begin
                        st  <= BOUNDS;
                        idx <= 3'd1;
                    end
                end
                BOUNDS: begin
                    if (skip) begin
                        skip <= 1'b0;       // Word 0 lands next cycle
                        idx  <= 3'd1;
                    end else if (bottom >= `OBJ_END_MARK) begin
                        st <= IDLE;
                    end else if (!inzone || badobj) begin
                        if (&cur_obj) begin
                            st <= IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            skip    <= 1'b1;
                        end
                    end else begin
                        idx <= 3'd2;
                        st  <= XPOS;
                    end
                end
                XPOS: begin
                    idx <= 3'd3;
                    st  <= PITCH;
                end
                PITCH: begin
                    idx <= 3'd4;
                    st  <= OFFSET;
                end
                OFFSET: begin
                    idx <= 3'd7;            // Scratch word from here on
                    st  <= ATTR;
                end
                ATTR: st <= UPDATE;
                UPDATE: begin
                    cur_obj <= cur_obj + 1'b1;  // Prime next entry while waiting
                    idx     <= '0;
                    st      <= ISSUE;
                end
                ISSUE: begin
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        if (last) begin
                            st <= IDLE;
                        end else begin
                            st  <= BOUNDS;
                            idx <= 3'd1;
                        end
                    end else if (hstart) begin
                        vline   <= vrf;     // Drop the rest, begin the new line
                        restart <= 1'b1;
                        st      <= IDLE;
                    end
                end
                default: st <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            BOUNDS: first <= top == vline[7:0];
            XPOS:   xpos  <= tbl_dout[8:0];
            PITCH:  pitch <= tbl_dout;
            OFFSET: start_off <= tbl_dout;
            ATTR: begin
                pal  <= tbl_dout[13:8];
                bank <= tbl_dout[6:4];
                prio <= tbl_dout[1:0];
            end
            UPDATE: begin
                run_off <= run_base;        // Before the pitch is added
                last    <= &cur_obj;
            end
            ISSUE: begin
                if (!dr_busy) begin
                    dr_cmd.xpos   <= xpos;
                    dr_cmd.offset <= run_off;
                    dr_cmd.bank   <= bank;
                    dr_cmd.prio   <= prio;
                    dr_cmd.pal    <= pal;
                end
            end
            default: ;
        endcase
    end

    // One command in flight with the draw engine
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy)
        else $error("dr_start while draw engine busy");

    // Only the scratch word is ever written back
    a_we_scratch: assert property (@(posedge clk) disable iff (rst)
        tbl_we |-> st == UPDATE && tbl_addr[2:0] == 3'd7)
        else $error("table write outside scratch update");

endmodule

/* verilog/obj_table_ram.sv */
// Object table RAM
// True dual port, host on one side and line scanner on the other
// Both reads registered, old data returned on a same-port write

`timescale 1ns/1ps
`include "obj_config.svh"

module obj_table_ram (
    input  logic               clk,

    // Host port
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  logic [15:0]        cpu_din,
    input  logic               cpu_we,
    output logic [15:0]        cpu_dout,

    // Scanner port
    input  obj_pkg::tbl_addr_t tbl_addr,
    input  logic [15:0]        tbl_din,
    input  logic               tbl_we,
    output logic [15:0]        tbl_dout
);

    logic [15:0] mem [0:`OBJ_CNT*`OBJ_WORDS-1];

    always_ff @(posedge clk) begin
        cpu_dout <= mem[cpu_addr];
        tbl_dout <= mem[tbl_addr];
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_din;   // Scanner wins a collision
        end
    end

    // Host and scanner must not write the same word together
    a_no_collide: assert property (@(posedge clk)
        cpu_we && tbl_we |-> cpu_addr != tbl_addr)
        else $error("table write collision at %0h", cpu_addr);

endmodule

/* verilog/obj_pkg.sv */
// Object subsystem types
// Width typedefs, draw command and pixel structs, scanner FSM states

`include "obj_config.svh"

package obj_pkg;

    typedef logic [$clog2(`OBJ_CNT*`OBJ_WORDS)-1:0] tbl_addr_t; // Object index, word index
    typedef logic [$clog2(`OBJ_CNT)-1:0]            obj_idx_t;
    typedef logic [$clog2(`OBJ_LINE_W)-1:0]         xpos_t;
    typedef logic [`OBJ_ROM_AW-1:0]                 rom_addr_t; // Bank over 15-bit offset

    // One draw request per visible object
    typedef struct packed {
        xpos_t       xpos;
        logic [15:0] offset;   // MSB doubles as hflip
        logic [2:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
    } obj_cmd_t;

    // Line buffer entry
    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;     // Zero is transparent
    } obj_pxl_t;

    // Scanner states, one table word per step
    typedef enum logic [2:0] {
        IDLE,
        BOUNDS,
        XPOS,
        PITCH,
        OFFSET,
        ATTR,
        UPDATE,
        ISSUE
    } scan_state_t;

endpackage

/* verilog/obj_config.svh */
// Object subsystem sizes
// Table geometry, line buffer width and sprite ROM span

`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// Object table
`define OBJ_CNT        128     // Entries
`define OBJ_WORDS      8       // 16-bit words per entry
`define OBJ_END_MARK   8'hF0   // Bottom at or above this ends the scan

// Video geometry
`define OBJ_VISIBLE    223     // Last visible line
`define OBJ_LINE_W     512     // Pixels per line buffer bank

// Sprite ROM
`define OBJ_ROM_AW     18      // Word address, bank plus offset
`define OBJ_MAX_WORDS  16      // Row length cap without terminator

`endif
